// File: logic/alu_core.sv
`timescale 1ns/1ps

module alu_core import alu_pkg::*; (
  input  alu_op_e         op_i,
  input  logic            word_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  output logic [XLEN-1:0] result_o,
  output logic            zero_o,
  output logic            less_o
);

  logic            sub;
  logic [XLEN-1:0] b_in;
  logic [XLEN-1:0] sum;
  logic            carry;
  logic            overflow;
  logic            right;
  logic            arith;
  logic [XLEN-1:0] shift;
  logic [XLEN-1:0] alu_res;

  // compares subtract too
  assign sub  = (op_i == ALU_SUB) || (op_i == ALU_SLT) || (op_i == ALU_SLTU);
  assign b_in = src2_i ^ {XLEN{sub}};

  assign {carry, sum} = {1'b0, src1_i} + {1'b0, b_in} + {{XLEN{1'b0}}, sub};

  assign overflow = (src1_i[XLEN-1] == b_in[XLEN-1]) && (sum[XLEN-1] != src1_i[XLEN-1]);

  // no carry out of a - b means a < b unsigned
  assign less_o = (op_i == ALU_SLTU) ? ~carry : (sum[XLEN-1] ^ overflow);
  assign zero_o = ~|sum;

  assign right = (op_i == ALU_SRL) || (op_i == ALU_SRA);
  assign arith = (op_i == ALU_SRA);

  alu_shifter shifter0 (
    .word_i  (word_i),
    .right_i (right),
    .arith_i (arith),
    .src_i   (src1_i),
    .shamt_i (src2_i[5:0]),
    .shift_o (shift)
  );

  always_comb begin
    case (op_i)
      ALU_ADD,
      ALU_SUB:   alu_res = sum;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:   alu_res = shift;
      ALU_SLT,
      ALU_SLTU:  alu_res = {{(XLEN-1){1'b0}}, less_o};
      ALU_PASSB: alu_res = src2_i;
      ALU_XOR:   alu_res = src1_i ^ src2_i;
      ALU_OR:    alu_res = src1_i | src2_i;
      ALU_AND:   alu_res = src1_i & src2_i;
      default:   alu_res = sum;
    endcase
  end

  // word variants sign-extend from bit 31
  assign result_o = word_i ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;

endmodule

// File: logic/alu_pkg.sv
package alu_pkg;

  // datapath width, the shifter word logic assumes 64
  localparam int XLEN = 64;

  // bit 3 picks the variant of the base function in bits 2:0
  typedef enum logic [3:0] {
    ALU_ADD   = 4'b0000,
    ALU_SUB   = 4'b1000,
    ALU_SLL   = 4'b0001,
    ALU_SLT   = 4'b0010,
    ALU_SLTU  = 4'b1010,
    ALU_PASSB = 4'b0011,
    ALU_XOR   = 4'b0100,
    ALU_SRL   = 4'b0101,
    ALU_SRA   = 4'b1101,
    ALU_OR    = 4'b0110,
    ALU_AND   = 4'b0111
  } alu_op_e;

endpackage

// File: logic/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; (
  input  logic            word_i,
  input  logic            right_i,
  input  logic            arith_i,
  input  logic [XLEN-1:0] src_i,
  input  logic [5:0]      shamt_i,
  output logic [XLEN-1:0] shift_o
);

  logic [5:0]      amt;
  logic            sign_bit;
  logic [XLEN-1:0] src_w;
  logic [XLEN-1:0] shr_in;
  logic [XLEN-1:0] shr_out;
  logic [XLEN-1:0] mask;
  logic [XLEN-1:0] right_res;
  logic [XLEN-1:0] raw_res;

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  // word ops only use the low five amount bits
  assign amt      = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;
  assign sign_bit = word_i ? src_i[31] : src_i[63];

  // word source, upper half zero or sign depending on arith
  assign src_w = word_i ? {{32{arith_i & sign_bit}}, src_i[31:0]} : src_i;

  // left shift goes through the same right shifter on reversed bits
  assign shr_in  = right_i ? src_w : bit_rev(src_i);
  assign shr_out = shr_in >> amt;

  // vacated top bits, filled with the sign for sra
  assign mask      = {XLEN{1'b1}} >> amt;
  assign right_res = shr_out | ({XLEN{arith_i & sign_bit}} & ~mask);

  assign raw_res = right_i ? right_res : bit_rev(shr_out);

  assign shift_o = word_i ? {{32{raw_res[31]}}, raw_res[31:0]} : raw_res;

endmodule

// File: logic/div_seq.sv
`timescale 1ns/1ps

module div_seq import alu_pkg::*, mdu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     start_i,
  input  md_req_t  req_i,
  output md_resp_t resp_o
);

  localparam logic [6:0] STEPS   = 7'(XLEN);
  localparam int         LATENCY = XLEN + 1;

  logic            busy_q;
  logic            done_q;
  logic [6:0]      cnt_q;
  logic [XLEN-1:0] dvsr_q;
  logic [XLEN-1:0] quo_q;
  logic [XLEN-1:0] rem_q;
  logic            q_neg_q;
  logic            r_neg_q;
  logic            rem_sel_q;
  logic [XLEN-1:0] result_q;
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;
  logic [XLEN:0]   shifted;
  logic [XLEN:0]   trial;
  logic            last;

  // div and rem are the signed ones (bit 0 clear)
  assign is_signed = ~req_i.op[0];
  assign a_neg     = is_signed & req_i.src1[XLEN-1];
  assign b_neg     = is_signed & req_i.src2[XLEN-1];
  assign mag_a     = a_neg ? -req_i.src1 : req_i.src1;
  assign mag_b     = b_neg ? -req_i.src2 : req_i.src2;

  // one restoring step, borrow out of bit XLEN means no subtract
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign trial   = shifted - {1'b0, dvsr_q};

  assign last = busy_q && (cnt_q == STEPS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (flush_i) begin
        busy_q <= 1'b0;
      end else if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (last) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 7'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      dvsr_q    <= mag_b;
      quo_q     <= mag_a;
      rem_q     <= '0;
      // zero divisor must keep the all-ones quotient unsigned
      q_neg_q   <= (a_neg ^ b_neg) & (|req_i.src2);
      r_neg_q   <= a_neg;
      rem_sel_q <= req_i.op[1];
    end else if (last) begin
      // min / -1 lands on min with rem 0 without extra logic
      result_q <= rem_sel_q ? (r_neg_q ? -rem_q : rem_q) : (q_neg_q ? -quo_q : quo_q);
    end else if (busy_q) begin
      rem_q <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
      quo_q <= {quo_q[XLEN-2:0], ~trial[XLEN]};
    end
  end

  assign resp_o = '{done: done_q, result: result_q};

  // done_q is seen one edge after the edge that sets it
  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    done_q |-> $past(start_i, LATENCY + 1));

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import alu_pkg::*, mdu_pkg::*; #(
  parameter int MUL_BITS = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  input  alu_op_e         alu_op_i,
  input  logic            word_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic            md_en_i,
  input  md_op_e          md_op_i,
  input  logic            flush_i,
  output logic [XLEN-1:0] result_o,
  output logic            zero_o,
  output logic            less_o,
  output logic            stall_o
);

  typedef enum logic {
    MD_IDLE,
    MD_BUSY
  } md_state_e;

  md_state_e       md_state_q;
  md_req_t         md_req;
  md_req_t         req_q;
  logic            launch;
  logic            mul_start;
  logic            div_start;
  md_resp_t        mul_resp;
  md_resp_t        div_resp;
  md_resp_t        md_resp;
  logic [XLEN-1:0] alu_result;

  alu_core alu0 (
    .op_i     (alu_op_i),
    .word_i   (word_i),
    .src1_i   (src1_i),
    .src2_i   (src2_i),
    .result_o (alu_result),
    .zero_o   (zero_o),
    .less_o   (less_o)
  );

  assign md_req    = '{op: md_op_i, src1: src1_i, src2: src2_i};
  assign launch    = (md_state_q == MD_IDLE) && md_en_i && !flush_i;
  assign mul_start = launch && !md_op_i[2];
  assign div_start = launch && md_op_i[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      md_state_q <= MD_IDLE;
      req_q      <= '0;
    end else if (launch) begin
      md_state_q <= MD_BUSY;
      req_q      <= md_req;
    end else if (flush_i || md_resp.done) begin
      md_state_q <= MD_IDLE;
    end
  end

  mul_seq #(.MUL_BITS(MUL_BITS)) mul0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .start_i (mul_start),
    .req_i   (md_req),
    .resp_o  (mul_resp)
  );

  div_seq div0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .start_i (div_start),
    .req_i   (md_req),
    .resp_o  (div_resp)
  );

  // in-flight op decides whose response counts
  assign md_resp  = req_q.op[2] ? div_resp : mul_resp;
  assign stall_o  = md_en_i && !md_resp.done;
  assign result_o = md_en_i ? md_resp.result : alu_result;

  a_stall_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
    !md_en_i |-> !stall_o);

  // source holds the request steady until the unit answers
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (md_state_q == MD_BUSY) && !md_resp.done && !flush_i |-> md_en_i && (md_req == req_q));

endmodule

// File: logic/mdu_pkg.sv
package mdu_pkg;

  import alu_pkg::*;

  // bit 2 set means divide or remainder
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  typedef struct packed {
    md_op_e          op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
  } md_req_t;

  // done is a single-cycle pulse, result valid with it
  typedef struct packed {
    logic            done;
    logic [XLEN-1:0] result;
  } md_resp_t;

endpackage

// File: logic/mul_seq.sv
`timescale 1ns/1ps

module mul_seq import alu_pkg::*, mdu_pkg::*; #(
  parameter int MUL_BITS = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     start_i,
  input  md_req_t  req_i,
  output md_resp_t resp_o
);

  localparam logic [6:0] STEPS = 7'(XLEN / MUL_BITS);

  logic              busy_q;
  logic              done_q;
  logic [6:0]        cnt_q;
  logic [2*XLEN-1:0] mcand_q;
  logic [XLEN-1:0]   mplier_q;
  logic [2*XLEN-1:0] prod_q;
  logic              neg_q;
  logic              hi_q;
  logic [XLEN-1:0]   result_q;
  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic [2*XLEN-1:0] prod_fix;
  logic              last;

  // mulh signs both, mulhsu only src1
  assign a_neg = ((req_i.op == MD_MULH) || (req_i.op == MD_MULHSU)) && req_i.src1[XLEN-1];
  assign b_neg = (req_i.op == MD_MULH) && req_i.src2[XLEN-1];
  assign mag_a = a_neg ? -req_i.src1 : req_i.src1;
  assign mag_b = b_neg ? -req_i.src2 : req_i.src2;

  assign last     = busy_q && (cnt_q == STEPS);
  assign prod_fix = neg_q ? -prod_q : prod_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (flush_i) begin
        busy_q <= 1'b0;
      end else if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (last) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 7'd1;
      end
    end
  end

  // MUL_BITS multiplier bits retired per step
  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q  <= {{XLEN{1'b0}}, mag_a};
      mplier_q <= mag_b;
      prod_q   <= '0;
      neg_q    <= a_neg ^ b_neg;
      hi_q     <= (req_i.op != MD_MUL);
    end else if (last) begin
      result_q <= hi_q ? prod_fix[2*XLEN-1:XLEN] : prod_fix[XLEN-1:0];
    end else if (busy_q) begin
      prod_q   <= prod_q + mcand_q * mplier_q[MUL_BITS-1:0];
      mcand_q  <= mcand_q << MUL_BITS;
      mplier_q <= mplier_q >> MUL_BITS;
    end
  end

  assign resp_o = '{done: done_q, result: result_q};

  // launcher must wait for done or flush
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> !busy_q);

endmodule

// File: project.f
logic/alu_pkg.sv
logic/mdu_pkg.sv
logic/alu_shifter.sv
logic/alu_core.sv
logic/mul_seq.sv
logic/div_seq.sv
logic/exec_unit.sv
testbench/exec_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the exec_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
  --top-module exec_unit_tb -o exec_unit_sim

./obj_dir/exec_unit_sim | tee /dev/stderr | grep -q "Simulation finished: PASS"
echo "run.sh: simulation passed"

// File: testbench/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb import alu_pkg::*, mdu_pkg::*; ();

  localparam int MUL_BITS = 2;
  localparam int ALU_VECS = 300 + 48 + 18;
  localparam int MD_OPS   = 8 * 7 + 2;
  localparam int TIMEOUT_CYCLES = 2 * (ALU_VECS + MD_OPS * 70) + 100;

  localparam logic [XLEN-1:0] MIN_VAL  = 64'h8000_0000_0000_0000;
  localparam logic [XLEN-1:0] MAX_VAL  = 64'h7fff_ffff_ffff_ffff;
  localparam logic [XLEN-1:0] ALL_ONES = '1;

  logic            clk;
  logic            rst_n;
  alu_op_e         alu_op;
  logic            word;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic            md_en;
  md_op_e          md_op;
  logic            flush;
  logic [XLEN-1:0] result;
  logic            zero;
  logic            less;
  logic            stall;
  logic            no_done_win;

  logic [31:0] lfsr = 32'h17ad_1a73;
  int          cycles = 0;
  int          stall_len = 0;

  logic [5:0]      shift_amts [4] = '{6'd0, 6'd31, 6'd32, 6'd63};
  logic [XLEN-1:0] shift_vals [2] = '{64'hf000_0000_8765_4321, 64'h0123_4567_89ab_cdef};
  logic [XLEN-1:0] cmp_a [6] = '{64'd5, MIN_VAL, MAX_VAL, MIN_VAL, 64'd0, ALL_ONES};
  logic [XLEN-1:0] cmp_b [6] = '{64'd5, 64'd1, ALL_ONES, MAX_VAL, MIN_VAL, ALL_ONES};
  logic [XLEN-1:0] md_a [5] = '{MIN_VAL, ALL_ONES, 64'h1234_5678_9abc_def0,
                                 64'hffff_ffff_ffff_fff9, MAX_VAL};
  logic [XLEN-1:0] md_b [5] = '{ALL_ONES, MIN_VAL, 64'd0, 64'd2, MIN_VAL};

  exec_unit #(.MUL_BITS(MUL_BITS)) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .alu_op_i (alu_op),
    .word_i   (word),
    .src1_i   (src1),
    .src2_i   (src2),
    .md_en_i  (md_en),
    .md_op_i  (md_op),
    .flush_i  (flush),
    .result_o (result),
    .zero_o   (zero),
    .less_o   (less),
    .stall_o  (stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "testbench stopped on error");
  endtask

  task automatic fail_value(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    abort_run();
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // includes the launch edge
  always @(posedge clk) begin
    stall_len <= stall ? stall_len + 1 : 0;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] v;
    logic            fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[XLEN-2:0], fb};
    end
    return v;
  endfunction

  function automatic logic uses_sub(input alu_op_e op);
    return (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
  endfunction

  function automatic logic ref_less(input alu_op_e op, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    return (op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
  endfunction

  function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic w,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0]  r;
    logic [5:0]       sh;
    logic signed [31:0] aw;
    sh = w ? {1'b0, b[4:0]} : b[5:0];
    aw = a[31:0];
    case (op)
      ALU_ADD:   r = a + b;
      ALU_SUB:   r = a - b;
      ALU_SLL:   r = a << sh;
      ALU_SLT:   r = {63'b0, $signed(a) < $signed(b)};
      ALU_SLTU:  r = {63'b0, a < b};
      ALU_PASSB: r = b;
      ALU_XOR:   r = a ^ b;
      ALU_SRL:   r = w ? {32'b0, a[31:0] >> sh} : a >> sh;
      ALU_SRA: begin
        if (w) begin
          r = {32'b0, aw >>> sh};
        end else begin
          r = $signed(a) >>> sh;
        end
      end
      ALU_OR:    r = a | b;
      ALU_AND:   r = a & b;
      default:   r = '0;
    endcase
    if (w) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    return r;
  endfunction

  function automatic logic [XLEN-1:0] ref_md(input md_op_e op, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0]      wa;
    logic [2*XLEN-1:0]      wb;
    logic [2*XLEN-1:0]      prod;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [XLEN-1:0]        res;
    sa = a;
    sb = b;
    // widen once so a single 128-bit product serves all multiplies
    wa = (op == MD_MULH || op == MD_MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    wb = (op == MD_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    prod = wa * wb;
    if (op[2] && b == '0) begin
      res = op[1] ? a : ALL_ONES;
    end else if (op[2] && !op[0] && a == MIN_VAL && b == ALL_ONES) begin
      res = op[1] ? '0 : a;
    end else begin
      case (op)
        MD_MUL:  res = prod[XLEN-1:0];
        MD_DIV:  res = sa / sb;
        MD_DIVU: res = a / b;
        MD_REM:  res = sa % sb;
        MD_REMU: res = a % b;
        default: res = prod[2*XLEN-1:XLEN];
      endcase
    end
    return res;
  endfunction

  function automatic int md_latency(input md_op_e op);
    return op[2] ? XLEN + 1 : XLEN / MUL_BITS + 1;
  endfunction

  a_alu_result: assert property (@(posedge clk) disable iff (!rst_n)
    !md_en |-> result == ref_alu(alu_op, word, src1, src2))
    else fail_value($sformatf("%s word %0b on %h %h gave %h",
                              alu_op.name(), word, src1, src2, result));

  a_alu_less: assert property (@(posedge clk) disable iff (!rst_n)
    !md_en && (alu_op == ALU_SLT || alu_op == ALU_SLTU) |-> less == ref_less(alu_op, src1, src2))
    else fail_value($sformatf("less %0b for %s on %h %h", less, alu_op.name(), src1, src2));

  a_alu_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !md_en && uses_sub(alu_op) |-> zero == (src1 == src2))
    else fail_value($sformatf("zero %0b for %s on %h %h", zero, alu_op.name(), src1, src2));

  a_no_alu_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !md_en |-> !stall)
    else fail_value("stall high with md_en low");

  a_md_result: assert property (@(posedge clk) disable iff (!rst_n)
    md_en && !stall |-> result == ref_md(md_op, src1, src2))
    else fail_value($sformatf("%s on %h %h gave %h", md_op.name(), src1, src2, result));

  // one extra count for the launch edge itself
  a_md_latency: assert property (@(posedge clk) disable iff (!rst_n)
    md_en && !stall |-> stall_len == md_latency(md_op) + 1)
    else fail_value($sformatf("%s stalled %0d edges, expected %0d",
                              md_op.name(), stall_len, md_latency(md_op) + 1));

  a_no_done_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
    no_done_win |-> !dut0.div_resp.done)
    else fail_value("divider finished after a flush");

  task automatic alu_vec(input alu_op_e op, input logic w, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
    md_en  = 1'b0;
    alu_op = op;
    word   = w;
    src1   = a;
    src2   = b;
    @(negedge clk);
  endtask

  task automatic md_run(input md_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    md_en = 1'b1;
    md_op = op;
    src1  = a;
    src2  = b;
    do begin
      @(negedge clk);
    end while (stall);
    // done cycle still needs its sampling edge
    @(negedge clk);
  endtask

  task automatic flush_div(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    md_en = 1'b1;
    md_op = MD_DIV;
    src1  = a;
    src2  = b;
    repeat (20) @(negedge clk);
    flush       = 1'b1;
    md_en       = 1'b0;
    no_done_win = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    repeat (70) @(negedge clk);
    no_done_win = 1'b0;
  endtask

  initial begin
    logic [XLEN-1:0] r;
    alu_op_e         aop;
    md_op_e          mop;
    rst_n       = 1'b0;
    alu_op      = ALU_ADD;
    word        = 1'b0;
    src1        = '0;
    src2        = '0;
    md_en       = 1'b0;
    md_op       = MD_MUL;
    flush       = 1'b0;
    no_done_win = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    a_reset_idle: assert (!stall && !dut0.mul0.busy_q && !dut0.div0.busy_q)
      else fail_value("unit not idle after reset");

    repeat (300) begin
      r   = rand_bits(4);
      aop = aop.first();
      repeat (r % 11) aop = aop.next();
      r = rand_bits(1);
      alu_vec(aop, r[0], rand_bits(64), rand_bits(64));
    end

    // shift edges, word variants of negative values
    for (int v = 0; v < 2; v++) begin
      for (int s = 0; s < 4; s++) begin
        for (int w = 0; w < 2; w++) begin
          alu_vec(ALU_SLL, w[0], shift_vals[1'(v)], {58'b0, shift_amts[2'(s)]});
          alu_vec(ALU_SRL, w[0], shift_vals[1'(v)], {58'b0, shift_amts[2'(s)]});
          alu_vec(ALU_SRA, w[0], shift_vals[1'(v)], {58'b0, shift_amts[2'(s)]});
        end
      end
    end

    for (int p = 0; p < 6; p++) begin
      alu_vec(ALU_SUB, 1'b0, cmp_a[3'(p)], cmp_b[3'(p)]);
      alu_vec(ALU_SLT, 1'b0, cmp_a[3'(p)], cmp_b[3'(p)]);
      alu_vec(ALU_SLTU, 1'b0, cmp_a[3'(p)], cmp_b[3'(p)]);
    end

    mop = mop.first();
    repeat (8) begin
      for (int p = 0; p < 5; p++) begin
        md_run(mop, md_a[3'(p)], md_b[3'(p)]);
      end
      repeat (2) md_run(mop, rand_bits(64), rand_bits(64));
      mop = mop.next();
    end

    flush_div(rand_bits(64), 64'd7);
    md_run(MD_MULH, MIN_VAL, 64'd3);
    alu_vec(ALU_ADD, 1'b0, '0, '0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
